/* hw/mipsPkg.sv */
// Shared types, encodings and address map for the two-stage MIPS-subset core
// Every RTL module imports this package inside its body
`default_nettype none

package mipsPkg;

	// Data and address word
	typedef logic [31:0] word_t;
	// Register index
	typedef logic [4:0] regAddr_t;

	// Major opcodes of the supported subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0d,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	// R-type function field
	typedef enum logic [5:0] {
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27
	} funct_t;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluNor = 3'd4
	} aluOp_t;

	// Decoded control for the execute stage
	typedef struct packed {
		logic   regDst;
		logic   aluSrc;
		logic   zeroExtImm;
		logic   regWrite;
		logic   memWrite;
		logic   memToReg;
		logic   branchEq;
		logic   branchNe;
		logic   jump;
		logic   link;
		logic   jumpReg;
		aluOp_t aluOp;
	} ctrl_t;

	// Fetch/decode pipeline register
	typedef struct packed {
		logic  valid;
		word_t instruction;
		word_t pcPlus4;
	} fetchReg_t;

	// Address map, shared depth of both memories
	localparam word_t textBase = 32'h0040_0000;
	localparam word_t dataBase = 32'h1001_0000;
	localparam word_t portAddr = 32'h1001_0800;
	localparam int memoryDepth = 512;
	localparam int memAddrBits = $clog2(memoryDepth);
	localparam regAddr_t linkReg = 5'd31;

endpackage

`default_nettype wire

/* hw/programMemory.sv */
// Instruction ROM, filled from program.hex at elaboration
// Combinational lookup of the word at a byte address in the text segment
`timescale 1ns/1ps
`default_nettype none

module programMemory (
	input  mipsPkg::word_t address,
	output mipsPkg::word_t instruction
);
	import mipsPkg::*;

	word_t rom [memoryDepth];
	word_t offset;
	logic inRange;

	initial $readmemh("program.hex", rom);

	// Byte offset into the text segment
	assign offset = address - textBase;
	assign inRange = offset < word_t'(memoryDepth * 4);
	// Outside the ROM reads as zero
	assign instruction = inRange ? rom[offset[2 +: memAddrBits]] : '0;

	// Fetch addresses inside the ROM must be word aligned
	always_comb begin
		if (inRange) assert (address[1:0] == 2'b00);
	end

endmodule

`default_nettype wire

/* hw/registerFile.sv */
// 32 x 32-bit register file
// Two asynchronous read ports, one write port on the rising clock edge
// Register zero always reads 0
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic             clk,
	input  logic             rst,
	input  logic             writeEnable,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::regAddr_t readAddr1,
	input  mipsPkg::regAddr_t readAddr2,
	input  mipsPkg::word_t   writeData,
	output mipsPkg::word_t   readData1,
	output mipsPkg::word_t   readData2
);
	import mipsPkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (writeEnable && writeAddr != '0) begin
			// Writes to $zero dropped here
			regs[writeAddr] <= writeData;
		end
	end

	// Hard-wired zero on both read ports
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
// Main decoder for the execute stage
// Turns opcode and function into the control struct, ALU operation included
// illegal is raised for any encoding outside the supported subset
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  mipsPkg::word_t instruction,
	output mipsPkg::ctrl_t ctrl,
	output logic           illegal
);
	import mipsPkg::*;

	opcode_t opcode;
	funct_t funct;

	assign opcode = opcode_t'(instruction[31:26]);
	assign funct = funct_t'(instruction[5:0]);

	always_comb begin
		// Everything off by default, ALU adds
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		illegal = 1'b0;
		case (opcode)
			opRType: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnNor: ctrl.aluOp = aluNor;
					fnJr: begin
						// Target comes from rs, nothing written
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
					end
					default: illegal = 1'b1;
				endcase
			end
			opAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opOri: begin
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExtImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOr;
			end
			opLw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			// Branches compare rs and rt through a subtract
			opBeq: begin ctrl.branchEq = 1'b1; ctrl.aluOp = aluSub; end
			opBne: begin ctrl.branchNe = 1'b1; ctrl.aluOp = aluSub; end
			opJ:   ctrl.jump = 1'b1;
			opJal: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* hw/arithmeticLogicUnit.sv */
// 32-bit ALU for add, sub, and, or and nor
// zero drives the beq/bne decision in the top level
`timescale 1ns/1ps
`default_nettype none

module arithmeticLogicUnit (
	input  mipsPkg::aluOp_t op,
	input  mipsPkg::word_t  a,
	input  mipsPkg::word_t  b,
	output mipsPkg::word_t  result,
	output logic            zero
);
	import mipsPkg::*;

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluNor:  result = ~(a | b);
			// Unused encodings
			default: result = '0;
		endcase
	end

	// Equal operands under sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
// Data RAM plus the memory-mapped I/O port
// Loads from portAddr return portIn zero-extended, stores there set portOut
// Everything else indexes a word RAM from dataBase
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
	input  logic           clk,
	input  logic           rst,
	input  mipsPkg::word_t address,
	input  mipsPkg::word_t writeData,
	input  logic           writeEnable,
	input  logic [7:0]     portIn,
	output mipsPkg::word_t readData,
	output mipsPkg::word_t portOut
);
	import mipsPkg::*;

	word_t ram [memoryDepth];
	word_t offset;
	logic isPort;
	logic inRange;

	assign isPort = (address == portAddr);
	// Byte offset into the data segment
	assign offset = address - dataBase;
	assign inRange = offset < word_t'(memoryDepth * 4);

	// Asynchronous read, port takes priority
	assign readData = isPort ? {24'b0, portIn} : (inRange ? ram[offset[2 +: memAddrBits]] : '0);

	always_ff @(posedge clk) begin
		if (writeEnable && inRange) ram[offset[2 +: memAddrBits]] <= writeData;
	end

	// Output port register
	always_ff @(posedge clk) begin
		if (rst) portOut <= '0;
		else if (writeEnable && isPort) portOut <= writeData;
	end

	// Stores must hit the RAM or the port, word aligned
	assert property (@(posedge clk) disable iff (rst)
		writeEnable |-> (address[1:0] == 2'b00) && (inRange || isPort));

endmodule

`default_nettype wire

/* hw/mipsProcessor.sv */
// Top level of the two-stage MIPS-subset core
// Fetch stage holds the PC and ROM
// Execute stage does decode through write-back
// Taken branches and jumps flush the one fetched instruction behind them
// retired/retiredPc report each executed instruction for checking
`timescale 1ns/1ps
`default_nettype none

module mipsProcessor (
	input  logic           clk,
	input  logic           rst,
	input  logic [7:0]     PortIn,
	output mipsPkg::word_t ALUResultOut,
	output mipsPkg::word_t PortOut,
	output logic           retired,
	output mipsPkg::word_t retiredPc
);
	import mipsPkg::*;

	word_t pc, pcPlus4, nextPc, instruction;
	fetchReg_t fetchReg;
	ctrl_t ctrl, ctrlGated;
	logic illegal, zero, takeBranch, redirect;
	word_t readData1, readData2, immExt, aluB, aluResult, memData;
	word_t branchTarget, jumpTarget, writeData;
	regAddr_t rs, rt, rd, writeReg;

	// Fetch stage
	assign pcPlus4 = pc + 32'd4;
	programMemory progMem (.address(pc), .instruction(instruction));

	always_ff @(posedge clk) begin
		if (rst) pc <= textBase;
		else pc <= nextPc;
	end

	// Fetch/decode register flushed on a redirect
	always_ff @(posedge clk) begin
		if (rst) fetchReg.valid <= 1'b0;
		else fetchReg.valid <= !redirect;
		fetchReg.instruction <= instruction;
		fetchReg.pcPlus4 <= pcPlus4;
	end

	// Execute stage fields
	assign rs = fetchReg.instruction[25:21];
	assign rt = fetchReg.instruction[20:16];
	assign rd = fetchReg.instruction[15:11];

	controlUnit control (.instruction(fetchReg.instruction), .ctrl(ctrl), .illegal(illegal));
	// Flushed slot has no side effects
	assign ctrlGated = fetchReg.valid ? ctrl : ctrl_t'('0);

	// Immediate zero-extended only for ori
	assign immExt = ctrlGated.zeroExtImm ? {16'b0, fetchReg.instruction[15:0]}
		: {{16{fetchReg.instruction[15]}}, fetchReg.instruction[15:0]};
	assign aluB = ctrlGated.aluSrc ? immExt : readData2;

	registerFile regFile (
		.clk(clk), .rst(rst), .writeEnable(ctrlGated.regWrite), .writeAddr(writeReg),
		.readAddr1(rs), .readAddr2(rt), .writeData(writeData),
		.readData1(readData1), .readData2(readData2)
	);

	arithmeticLogicUnit alu (
		.op(ctrlGated.aluOp), .a(readData1), .b(aluB), .result(aluResult), .zero(zero)
	);

	dataMemory dataMem (
		.clk(clk), .rst(rst), .address(aluResult), .writeData(readData2),
		.writeEnable(ctrlGated.memWrite), .portIn(PortIn),
		.readData(memData), .portOut(PortOut)
	);

	// Branch and jump targets
	assign branchTarget = fetchReg.pcPlus4 + {immExt[29:0], 2'b00};
	assign jumpTarget = {fetchReg.pcPlus4[31:28], fetchReg.instruction[25:0], 2'b00};
	assign takeBranch = (ctrlGated.branchEq && zero) || (ctrlGated.branchNe && !zero);
	assign redirect = takeBranch || ctrlGated.jump || ctrlGated.jumpReg;

	always_comb begin
		if (ctrlGated.jumpReg) nextPc = readData1;
		else if (ctrlGated.jump) nextPc = jumpTarget;
		else if (takeBranch) nextPc = branchTarget;
		else nextPc = pcPlus4;
	end

	// Write-back selection with jal linking into $ra
	assign writeReg = ctrlGated.link ? linkReg : (ctrlGated.regDst ? rd : rt);
	assign writeData = ctrlGated.link ? fetchReg.pcPlus4
		: (ctrlGated.memToReg ? memData : aluResult);

	assign ALUResultOut = aluResult;
	assign retired = fetchReg.valid;
	assign retiredPc = fetchReg.pcPlus4 - 32'd4;

	// Only supported encodings ever execute
	assert property (@(posedge clk) disable iff (rst) fetchReg.valid |-> !illegal);

endmodule

`default_nettype wire

/* bench/isaModel.svh */
// Architectural model of the MIPS subset, one instruction per call
// Included inside the testbench module after the package import
// resetModel loads program.hex, commitInstruction retires the predicted instruction
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t progImage [memoryDepth];
word_t archRegs [32];
word_t archMem [memoryDepth];
word_t modelPc;
word_t modelPortOut;
// Prediction for the instruction sitting at modelPc
word_t predAlu;
word_t predNextPc;
logic predCheckAlu;
// Set once the program jumps onto itself
logic reachedEnd;

function automatic word_t signExt(input word_t ins);
	return {{16{ins[15]}}, ins[15:0]};
endfunction

// Word slot of a byte address inside a segment
function automatic int wordIndex(input word_t addr, input word_t base);
	word_t off;
	off = addr - base;
	return int'(off[2 +: memAddrBits]);
endfunction

task automatic writeReg(input regAddr_t r, input word_t value);
	// $zero stays 0
	if (r != 5'd0) archRegs[r] = value;
endtask

// ALU value and next pc of the instruction at modelPc, no state change
task automatic predictInstruction;
	word_t ins;
	word_t a;
	word_t b;
	opcode_t op;
	funct_t fn;
	ins = progImage[wordIndex(modelPc, textBase)];
	op = opcode_t'(ins[31:26]);
	fn = funct_t'(ins[5:0]);
	a = archRegs[ins[25:21]];
	b = archRegs[ins[20:16]];
	predAlu = '0;
	predCheckAlu = 1'b1;
	predNextPc = modelPc + 32'd4;
	case (op)
		opRType: begin
			case (fn)
				fnAdd: predAlu = a + b;
				fnSub: predAlu = a - b;
				fnAnd: predAlu = a & b;
				fnOr:  predAlu = a | b;
				fnNor: predAlu = ~(a | b);
				fnJr: begin
					predCheckAlu = 1'b0;
					predNextPc = a;
				end
				default: predCheckAlu = 1'b0;
			endcase
		end
		// Effective address for loads and stores
		opAddi, opLw, opSw: predAlu = a + signExt(ins);
		opOri: predAlu = a | {16'b0, ins[15:0]};
		opBeq: begin
			predCheckAlu = 1'b0;
			if (a == b) predNextPc = modelPc + 32'd4 + (signExt(ins) << 2);
		end
		opBne: begin
			predCheckAlu = 1'b0;
			if (a != b) predNextPc = modelPc + 32'd4 + (signExt(ins) << 2);
		end
		// Region bits from pc+4
		opJ, opJal: begin
			predCheckAlu = 1'b0;
			predNextPc = {predNextPc[31:28], ins[25:0], 2'b00};
		end
		default: predCheckAlu = 1'b0;
	endcase
endtask

task automatic commitInstruction(input logic [7:0] portValue);
	word_t ins;
	word_t b;
	opcode_t op;
	ins = progImage[wordIndex(modelPc, textBase)];
	op = opcode_t'(ins[31:26]);
	b = archRegs[ins[20:16]];
	case (op)
		opRType: if (funct_t'(ins[5:0]) != fnJr) writeReg(ins[15:11], predAlu);
		opAddi, opOri: writeReg(ins[20:16], predAlu);
		opLw: begin
			// Port reads the byte on the bus this cycle
			if (predAlu == portAddr) writeReg(ins[20:16], {24'b0, portValue});
			else writeReg(ins[20:16], archMem[wordIndex(predAlu, dataBase)]);
		end
		opSw: begin
			if (predAlu == portAddr) modelPortOut = b;
			else archMem[wordIndex(predAlu, dataBase)] = b;
		end
		opJal: writeReg(linkReg, modelPc + 32'd4);
		default: ;
	endcase
	if (predNextPc == modelPc) reachedEnd = 1'b1;
	modelPc = predNextPc;
	predictInstruction();
endtask

task automatic resetModel;
	$readmemh("program.hex", progImage);
	foreach (archRegs[i]) archRegs[i] = '0;
	foreach (archMem[i]) archMem[i] = '0;
	modelPc = textBase;
	modelPortOut = '0;
	reachedEnd = 1'b0;
	predictInstruction();
endtask

`endif

/* bench/mipsProcessorTb.sv */
// Testbench for the two-stage MIPS-subset core
// Runs program.hex on the DUT and on an ISA model in lockstep
// Concurrent assertions compare every retired instruction with the model
`timescale 1ns/1ps
`default_nettype none

module mipsProcessorTb;
	import mipsPkg::*;

	logic clk;
	logic rst;
	logic [7:0] PortIn;
	word_t ALUResultOut;
	word_t PortOut;
	logic retired;
	word_t retiredPc;
	word_t lcgState;

	// Model view for the checks, refreshed on each rising edge
	word_t expPc;
	word_t expAlu;
	word_t expPortOut;
	logic expCheckAlu;
	logic expRedirect;

	`include "isaModel.svh"

	mipsProcessor uut (
		.clk(clk), .rst(rst), .PortIn(PortIn), .ALUResultOut(ALUResultOut),
		.PortOut(PortOut), .retired(retired), .retiredPc(retiredPc)
	);

	function automatic word_t lcgNext(input word_t state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
		failRun($sformatf("[FAIL] %s expected %h, got %h", name, expected, actual));
	endtask

	always #5 clk = ~clk;

	// New port byte every cycle, 1 ns after the edge
	always @(posedge clk) begin
		#1;
		lcgState = lcgNext(lcgState);
		PortIn = lcgState[23:16];
	end

	// Model retires together with the DUT
	always @(posedge clk) begin
		if (!rst && retired) commitInstruction(PortIn);
		expPc <= modelPc;
		expAlu <= predAlu;
		expCheckAlu <= predCheckAlu;
		expRedirect <= (predNextPc != modelPc + 32'd4);
		expPortOut <= modelPortOut;
	end

	// First fetch from textBase retires in the second cycle after reset
	assert property (@(posedge clk) $fell(rst) |-> !retired)
		else failRun("an instruction retired one cycle after reset fell");
	assert property (@(posedge clk) $fell(rst) |=> retired && retiredPc == textBase)
		else failRun("first instruction did not retire from textBase two cycles after reset");

	assert property (@(posedge clk) disable iff (rst) retired |-> retiredPc == expPc)
		else reportMismatch("retiredPc", $sampled(expPc), $sampled(retiredPc));
	// Arithmetic results and load/store addresses
	assert property (@(posedge clk) disable iff (rst)
		retired && expCheckAlu |-> ALUResultOut == expAlu)
		else reportMismatch("ALUResultOut", $sampled(expAlu), $sampled(ALUResultOut));
	assert property (@(posedge clk) disable iff (rst) PortOut == expPortOut)
		else reportMismatch("PortOut", $sampled(expPortOut), $sampled(PortOut));

	// One empty slot after each redirect, none elsewhere
	assert property (@(posedge clk) disable iff (rst) retired && expRedirect |=> !retired)
		else failRun("instruction behind a taken redirect was not flushed");
	assert property (@(posedge clk) disable iff (rst) retired && !expRedirect |=> retired)
		else failRun("retired dropped without a taken redirect");
	assert property (@(posedge clk) disable iff (rst) $fell(retired) |=> retired)
		else failRun("retired stayed low for more than one cycle after a redirect");

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		PortIn = 8'h00;
		lcgState = 32'hf339;
		resetModel();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// Run until the model hits the final self-jump
		cycles = 0;
		while (!reachedEnd && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		// Let the checks see the last few retires
		repeat (4) @(posedge clk);
		if (reachedEnd) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			failRun("program never reached its final self-loop");
		end
	end

endmodule

`default_nettype wire

/* program.hex */
// One 32-bit instruction word per line, in hex, from textBase upward
// Trailing comments give the assembly, $1 ends up holding dataBase
34011001 // ori  $1, $0, 0x1001
20020010 // addi $2, $0, 16
00210820 // loop: add $1, $1, $1
2042ffff // addi $2, $2, -1
1440fffd // bne  $2, $0, loop
2003fffb // addi $3, $0, -5
34048001 // ori  $4, $0, 0x8001
00642822 // sub  $5, $3, $4
00643024 // and  $6, $3, $4
00643825 // or   $7, $3, $4
00644027 // nor  $8, $3, $4
ac250004 // sw   $5, 4($1)
8c290004 // lw   $9, 4($1)
01275020 // add  $10, $9, $7
8c2b0800 // lw   $11, 0x800($1)
016a6020 // add  $12, $11, $10
ac2c0800 // sw   $12, 0x800($1)
20000007 // addi $0, $0, 7
00046820 // add  $13, $0, $4
11a40001 // beq  $13, $4, +1
200e0001 // addi $14, $0, 1
11a00001 // beq  $13, $0, +1
0c100019 // jal  func
ac3f0008 // sw   $31, 8($1)
0810001a // j    end
03e00008 // func: jr $31
0810001a // end: j end

/* all.f */
+incdir+bench
hw/mipsPkg.sv
hw/programMemory.sv
hw/registerFile.sv
hw/controlUnit.sv
hw/arithmeticLogicUnit.sv
hw/dataMemory.sv
hw/mipsProcessor.sv
bench/mipsProcessorTb.sv

/* Makefile */
# Verilator flow for the MIPS-subset core
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = mipsProcessorTb
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSTEXT  = PASS: all tests

.PHONY: all lint build test clean

all: test

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
